// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_mem_subsystem \
	&& ./obj_dir/Vtb_mem_subsystem | tee sim.log \
	|| { echo "Build or run error"; exit 1; }
grep -q "SIMULATION PASSED" sim.log \
	&& echo "Result: pass" \
	|| { echo "Result: fail"; exit 1; }

// File: src.f
verilog/mem_stage_pkg.sv
verilog/address_generator.sv
verilog/store_formatter.sv
verilog/control_registers.sv
verilog/memory_access_stage.sv
verilog/line_store.sv
verilog/mem_subsystem_top.sv
verification/mem_stage_sva.sv
verification/tb_mem_subsystem.sv

// File: verification/mem_stage_sva.sv
// ----------------------------------------
// Memory stage assertions
// Aligned accesses, quiet strobes on flush and
// no writeback after a flushed cycle
// ----------------------------------------
`timescale 1ns/1ps

module mem_stage_sva (
	input logic clk,
	input logic arst_n_i,
	input logic flush_i,
	input logic daccess_i,
	input logic dwrite_i,
	input logic unaligned_i,
	input logic wb_valid_i
);

	a_aligned_access: assert property (@(posedge clk) disable iff (!arst_n_i)
		daccess_i |-> !unaligned_i)
		else $error("Cache access issued with an unaligned address");

	// Flush must hold both strobes low
	a_flush_no_write: assert property (@(posedge clk) disable iff (!arst_n_i)
		flush_i |-> !dwrite_i && !daccess_i)
		else $error("Cache strobe raised during flush");

	a_flush_no_writeback: assert property (@(posedge clk) disable iff (!arst_n_i)
		flush_i |=> !wb_valid_i)
		else $error("Writeback flagged after a flushed cycle");

endmodule

bind memory_access_stage mem_stage_sva u_sva (
	.clk         (clk),
	.arst_n_i    (arst_n_i),
	.flush_i     (flush_i),
	.daccess_i   (daccess_o),
	.dwrite_i    (dwrite_o),
	.unaligned_i (unaligned_addr),
	.wb_valid_i  (has_writeback_o)
);

// File: verification/tb_mem_subsystem.sv
// ----------------------------------------
// Memory subsystem testbench
// Random memory and control register ops from an LFSR,
// checked against a byte mirror and register model
// ----------------------------------------
`timescale 1ns/1ps

module tb_mem_subsystem;
	import mem_stage_pkg::*;

	localparam int PERIOD       = 40;
	localparam int NUM_OPS      = 400;
	localparam int DIRECTED     = 8;
	localparam int TOTAL_CYCLES = 4 + LINE_COUNT + DIRECTED + NUM_OPS + 1;
	localparam int TIMEOUT_NS   = (TOTAL_CYCLES + 20) * PERIOD;

	logic              clk;
	logic              arst_n_i;
	logic              flush_i;
	logic [31:0]       instruction_i;
	logic [1:0]        strand_i;
	logic [31:0]       pc_i;
	logic [LINE_W-1:0] store_value_i;
	logic [LINE_W-1:0] result_i;
	logic [15:0]       mask_i;
	logic [3:0]        reg_lane_select_i;
	logic [31:0]       base_addr_i;
	logic [31:0]       strided_offset_i;
	logic              has_writeback_i;
	logic [6:0]        writeback_reg_i;
	logic              writeback_is_vector_i;
	logic [31:0]       instruction_o;
	logic              has_writeback_o;
	logic [6:0]        writeback_reg_o;
	logic              writeback_is_vector_o;
	logic [15:0]       mask_o;
	logic [LINE_W-1:0] result_o;
	logic [3:0]        cache_lane_select_o;
	logic              was_access_o;
	logic [1:0]        strand_o;
	logic [31:0]       pc_o;
	logic [3:0]        strand_enable_o;
	logic              daccess_o;
	logic              dwrite_o;
	logic [LINE_W-1:0] load_line_o;

	// Op for the current cycle
	logic [31:0]       c_instr;
	logic              c_flush;
	logic [1:0]        c_strand;
	logic [LINE_W-1:0] c_sv;
	logic [LINE_W-1:0] c_res;
	logic [15:0]       c_mask;
	logic [3:0]        c_sel;
	logic [31:0]       c_base;
	logic [31:0]       c_off;
	logic              c_hwb;
	logic [6:0]        c_wbreg;
	logic [31:0]       c_pc;
	logic              c_wbvec;

	// Expected registered outputs of the previous op
	logic [31:0]       e_instr;
	logic              e_hwb;
	logic [6:0]        e_wbreg;
	logic [15:0]       e_mask;
	logic [1:0]        e_strand;
	logic              e_access;
	logic [LINE_W-1:0] e_res;
	logic              e_load;
	logic [LINE_W-1:0] e_line;
	logic [31:0]       e_pc;
	logic              e_wbvec;
	logic [3:0]        e_lane;

	logic [7:0]        mirror [LINE_COUNT * LINE_BYTES];
	logic [31:0]       m_scratch;
	logic [3:0]        m_en;
	logic [15:0]       lfsr;
	int                checks;
	int                errors;

	mem_subsystem_top u_dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("Timeout: the test did not finish within %0d ns", TIMEOUT_NS);
		$display("SIMULATION FAILED");
		$finish;
	end

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [LINE_W-1:0] random_line();
		logic [LINE_W-1:0] v;
		for (int i = 0; i < LANES; i++)
			v[32 * i +: 32] = take_bits(32);
		return v;
	endfunction

	// Lowest address takes the low byte of the register word
	function automatic void put_word(input int a, input logic [31:0] v);
		for (int i = 0; i < 4; i++)
			mirror[a + i] = v[8 * i +: 8];
	endfunction

	function automatic logic [LINE_W-1:0] mirror_line(input int a);
		logic [LINE_W-1:0] line;
		int                base;
		base = (a / LINE_BYTES) * LINE_BYTES;
		for (int k = 0; k < LINE_BYTES; k++)
			line[8 * (LINE_BYTES - 1 - k) +: 8] = mirror[base + k]; // Byte 0 on top
		return line;
	endfunction

	task automatic compare_value(input string name, input logic [LINE_W-1:0] exp_v,
		input logic [LINE_W-1:0] act_v);
		checks++;
		assert (act_v === exp_v)
		else
		begin
			errors++;
			$display("[FAIL] at %0d ns: %s expected %0h, got %0h", $time, name, exp_v, act_v);
		end
	endtask

	task automatic choose_random_op();
		instr_word_u w;
		logic [31:0] r;
		logic [31:0] addr;
		logic [3:0]  op;
		r = take_bits(3);
		if (r == 0)
			op = MEM_CONTROL_REG;
		else
		begin
			r  = take_bits(4);
			op = r[3:0];
		end
		w = take_bits(32);
		r = take_bits(3);
		w.mem.fmt     = (r == 0) ? 2'b01 : FMT_MEM; // Some non-memory instructions
		w.mem.op_type = op;
		r = take_bits(1);
		w.mem.is_load = r[0];
		r = take_bits(3);
		if (op == MEM_CONTROL_REG)
		begin
			case (r[2:0])
				3'd0, 3'd1:
					w.cr.index = CR_SCRATCH;
				3'd2:
					w.cr.index = CR_STRAND_ID;
				3'd3:
					w.cr.index = CR_STRAND_EN;
				3'd4:
					w.cr.index = CR_HALT;
				default: ; // Random index
			endcase
		end
		c_instr = w;
		r = take_bits(3);
		c_flush = (r == 0);
		c_sv    = random_line();
		c_res   = random_line();
		r = take_bits(16);
		c_mask  = r[15:0];
		r = take_bits(4);
		c_sel   = r[3:0];
		c_base  = take_bits(9) & ~32'd3;
		c_off   = take_bits(9) & ~32'd3;
		r = take_bits(9);
		c_strand = r[8:7];
		c_hwb    = r[0];
		r = take_bits(7);
		c_wbreg  = r[6:0];
		c_pc     = take_bits(32);
		r = take_bits(1);
		c_wbvec  = r[0];
		addr = take_bits(10);
		case (op)
			MEM_B, MEM_BX: ;
			MEM_S, MEM_SX:
				addr[0] = 1'b0;
			MEM_BLOCK, MEM_BLOCK_M, MEM_BLOCK_IM:
				addr[5:0] = 6'd0;
			default:
				addr[1:0] = 2'b00;
		endcase
		c_res[31:0] = addr;
		c_res[32 * (15 - int'(c_sel)) +: 32] = addr; // Gather pointer
	endtask

	task automatic fill_line_op(input int line);
		c_instr     = {FMT_MEM, 1'b0, MEM_BLOCK, 25'd0};
		c_flush     = 1'b0;
		c_mask      = 16'hffff;
		c_sv        = random_line();
		c_res       = '0;
		c_res[31:0] = 32'(line * LINE_BYTES);
	endtask

	task automatic cr_transfer_op(input logic [4:0] idx, input logic load, input logic flush,
		input logic [31:0] value);
		instr_word_u w;
		w             = '0;
		w.cr.fmt      = FMT_MEM;
		w.cr.is_load  = load;
		w.cr.op_type  = MEM_CONTROL_REG;
		w.cr.index    = idx;
		c_instr       = w;
		c_flush       = flush;
		c_sv[31:0]    = value;
	endtask

	task automatic model_and_check();
		instr_word_u w;
		logic [3:0]  op;
		logic        is_mem;
		logic        is_cr;
		logic        access;
		logic [31:0] addr;
		logic [31:0] rd;
		int          a;
		compare_value("instruction_o", LINE_W'(e_instr), LINE_W'(instruction_o));
		compare_value("has_writeback_o", LINE_W'(e_hwb), LINE_W'(has_writeback_o));
		compare_value("writeback_reg_o", LINE_W'(e_wbreg), LINE_W'(writeback_reg_o));
		compare_value("writeback_is_vector_o", LINE_W'(e_wbvec),
			LINE_W'(writeback_is_vector_o));
		compare_value("mask_o", LINE_W'(e_mask), LINE_W'(mask_o));
		compare_value("strand_o", LINE_W'(e_strand), LINE_W'(strand_o));
		compare_value("pc_o", LINE_W'(e_pc), LINE_W'(pc_o));
		compare_value("cache_lane_select_o", LINE_W'(e_lane), LINE_W'(cache_lane_select_o));
		compare_value("was_access_o", LINE_W'(e_access), LINE_W'(was_access_o));
		compare_value("result_o", e_res, result_o);
		compare_value("strand_enable_o", LINE_W'(m_en), LINE_W'(strand_enable_o));
		if (e_load)
			compare_value("load_line_o", e_line, load_line_o);

		w      = c_instr;
		op     = w.mem.op_type;
		is_mem = w.mem.fmt == FMT_MEM;
		is_cr  = is_mem && op == MEM_CONTROL_REG;
		access = is_mem && !is_cr && !c_flush;
		if (op >= MEM_STRIDED && !c_mask[4'd15 - c_sel])
			access = 1'b0; // Lane masked off
		compare_value("daccess_o", LINE_W'(access), LINE_W'(daccess_o));
		compare_value("dwrite_o", LINE_W'(access && !w.mem.is_load), LINE_W'(dwrite_o));

		if (op >= MEM_STRIDED && op <= MEM_STRIDED_IM)
			addr = c_base + c_off;
		else if (op >= MEM_SCGATH)
			addr = c_res[32 * (15 - int'(c_sel)) +: 32];
		else
			addr = c_res[31:0];
		a = int'(addr[9:0]);

		if (access && !w.mem.is_load)
		begin
			case (op)
				MEM_B, MEM_BX:
					mirror[a] = c_sv[7:0];
				MEM_S, MEM_SX:
				begin
					mirror[a]     = c_sv[7:0];
					mirror[a + 1] = c_sv[15:8];
				end
				MEM_BLOCK, MEM_BLOCK_M, MEM_BLOCK_IM:
				begin
					for (int l = 0; l < LANES; l++)
					begin
						if (c_mask[15 - l])
							put_word(a + 4 * l, c_sv[32 * (15 - l) +: 32]);
					end
				end
				MEM_L, MEM_SYNC:
					put_word(a, c_sv[31:0]);
				default:
					put_word(a, c_sv[32 * (15 - int'(c_sel)) +: 32]); // Strided or scatter
			endcase
		end

		case (w.cr.index)
			CR_STRAND_ID:
				rd = {CORE_ID, c_strand};
			CR_SCRATCH:
				rd = m_scratch;
			CR_STRAND_EN:
				rd = {28'd0, m_en};
			default:
				rd = '0;
		endcase
		if (is_cr && !w.cr.is_load && !c_flush)
		begin
			case (w.cr.index)
				CR_SCRATCH:
					m_scratch = c_sv[31:0];
				CR_STRAND_EN:
					m_en = c_sv[3:0];
				CR_HALT:
					m_en = 4'b0000;
				default: ;
			endcase
		end

		e_instr  = c_flush ? OP_NOP : c_instr;
		e_hwb    = c_hwb && !c_flush;
		e_wbreg  = c_wbreg;
		e_wbvec  = c_wbvec;
		e_mask   = c_mask;
		e_strand = c_strand;
		e_pc     = c_pc;
		e_lane   = addr[5:2]; // Word within the line
		e_access = access;
		e_res    = is_cr ? LINE_W'(rd) : c_res;
		e_load   = access && w.mem.is_load;
		e_line   = mirror_line(a);
	endtask

	task automatic run_cycle();
		@(posedge clk);
		flush_i               <= c_flush;
		instruction_i         <= c_instr;
		strand_i              <= c_strand;
		pc_i                  <= c_pc;
		store_value_i         <= c_sv;
		result_i              <= c_res;
		mask_i                <= c_mask;
		reg_lane_select_i     <= c_sel;
		base_addr_i           <= c_base;
		strided_offset_i      <= c_off;
		has_writeback_i       <= c_hwb;
		writeback_reg_i       <= c_wbreg;
		writeback_is_vector_i <= c_wbvec;
		@(negedge clk);
		model_and_check();
	endtask

	initial
	begin
		lfsr                  = 16'd13;
		checks                = 0;
		errors                = 0;
		arst_n_i              = 1'b0;
		flush_i               = 1'b0;
		instruction_i         = OP_NOP;
		strand_i              = '0;
		pc_i                  = '0;
		store_value_i         = '0;
		result_i              = '0;
		mask_i                = '0;
		reg_lane_select_i     = '0;
		base_addr_i           = '0;
		strided_offset_i      = '0;
		has_writeback_i       = 1'b0;
		writeback_reg_i       = '0;
		writeback_is_vector_i = 1'b0;
		{c_flush, c_strand, c_sv, c_res, c_mask, c_sel} = '0;
		{c_base, c_off, c_hwb, c_wbreg, c_pc, c_wbvec} = '0;
		c_instr   = OP_NOP;
		e_instr   = OP_NOP;
		{e_hwb, e_wbreg, e_mask, e_strand, e_access, e_res, e_load, e_line} = '0;
		{e_pc, e_wbvec, e_lane} = '0;
		m_scratch = '0;
		m_en      = 4'b0001;

		repeat (2) @(posedge clk);
		@(negedge clk);
		compare_value("instruction_o", LINE_W'(OP_NOP), LINE_W'(instruction_o));
		compare_value("has_writeback_o", '0, LINE_W'(has_writeback_o));
		compare_value("was_access_o", '0, LINE_W'(was_access_o));
		compare_value("daccess_o", '0, LINE_W'(daccess_o));
		compare_value("dwrite_o", '0, LINE_W'(dwrite_o));
		compare_value("strand_enable_o", LINE_W'(4'b0001), LINE_W'(strand_enable_o));
		@(posedge clk);
		arst_n_i <= 1'b1;

		// Known contents in every line first
		for (int l = 0; l < LINE_COUNT; l++)
		begin
			fill_line_op(l);
			run_cycle();
		end

		cr_transfer_op(CR_SCRATCH, 1'b0, 1'b0, 32'hcafe_f00d);
		run_cycle();
		cr_transfer_op(CR_SCRATCH, 1'b1, 1'b0, 32'h0);
		run_cycle();
		cr_transfer_op(CR_SCRATCH, 1'b0, 1'b1, 32'h1234_5678);
		run_cycle();
		cr_transfer_op(CR_SCRATCH, 1'b1, 1'b0, 32'h0);
		run_cycle();
		cr_transfer_op(CR_STRAND_ID, 1'b1, 1'b0, 32'h0);
		run_cycle();
		cr_transfer_op(CR_STRAND_EN, 1'b0, 1'b0, 32'h0000_000b);
		run_cycle();
		cr_transfer_op(CR_HALT, 1'b0, 1'b0, 32'h0);
		run_cycle();
		cr_transfer_op(CR_STRAND_EN, 1'b1, 1'b0, 32'h0);
		run_cycle();

		repeat (NUM_OPS)
		begin
			choose_random_op();
			run_cycle();
		end

		// Idle cycle retires the last op
		c_instr = OP_NOP;
		c_flush = 1'b0;
		run_cycle();

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: verilog/address_generator.sv
// ----------------------------------------
// Address generator
// Picks scalar, block, strided or gather address and
// splits it into line address and word lane
// ----------------------------------------
`timescale 1ns/1ps

module address_generator (
	input  logic [3:0]                       op_type_i,
	input  logic [mem_stage_pkg::LINE_W-1:0] result_i,
	input  logic [31:0]                      base_addr_i,
	input  logic [31:0]                      strided_offset_i,
	input  logic [3:0]                       reg_lane_select_i,
	output logic [31:0]                      daddress_o,
	output logic [3:0]                       cache_lane_o
);
	import mem_stage_pkg::*;

	logic [31:0] strided_ptr;
	logic [31:0] lane_ptr;
	logic [31:0] eff_addr;

	assign strided_ptr = base_addr_i + strided_offset_i;

	// Lane 0 sits in the top word
	assign lane_ptr = result_i[{~reg_lane_select_i, 5'd0} +: 32];

	always_comb
	begin
		case (op_type_i)
			MEM_STRIDED, MEM_STRIDED_M, MEM_STRIDED_IM:
				eff_addr = strided_ptr;
			MEM_SCGATH, MEM_SCGATH_M, MEM_SCGATH_IM:
				eff_addr = lane_ptr;
			default:
				eff_addr = result_i[31:0]; // Scalar or block
		endcase
	end

	assign daddress_o   = eff_addr & ~32'(LINE_BYTES - 1);
	assign cache_lane_o = eff_addr[5:2];

endmodule

// File: verilog/control_registers.sv
// ----------------------------------------
// Control registers
// Strand ID, scratch and strand enable/halt
// ----------------------------------------
`timescale 1ns/1ps

module control_registers (
	input  logic        clk,
	input  logic        arst_n_i,
	input  logic        wr_en_i,
	input  logic [4:0]  cr_index_i,
	input  logic [31:0] wr_value_i,
	input  logic [1:0]  strand_i,
	output logic [31:0] rd_value_o,
	output logic [3:0]  strand_enable_o
);
	import mem_stage_pkg::*;

	logic [31:0] scratch;

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			scratch         <= '0;
			strand_enable_o <= 4'b0001; // Strand 0 runs out of reset
		end
		else if (wr_en_i)
		begin
			case (cr_index_i)
				CR_SCRATCH:
					scratch <= wr_value_i;
				CR_STRAND_EN:
					strand_enable_o <= wr_value_i[3:0];
				CR_HALT:
					strand_enable_o <= 4'b0000;
				default: ;
			endcase
		end
	end

	always_comb
	begin
		case (cr_index_i)
			CR_STRAND_ID:
				rd_value_o = {CORE_ID, strand_i};
			CR_SCRATCH:
				rd_value_o = scratch;
			CR_STRAND_EN:
				rd_value_o = {28'd0, strand_enable_o};
			default:
				rd_value_o = '0; // HALT and unknown
		endcase
	end

endmodule

// File: verilog/line_store.sv
// ----------------------------------------
// Line store
// Small data line memory, byte-masked writes,
// registered line reads
// ----------------------------------------
`timescale 1ns/1ps

module line_store (
	input  logic                                 clk,
	input  logic                                 arst_n_i,
	input  logic                                 access_i,
	input  logic                                 write_i,
	input  logic [31:0]                          addr_i,
	input  logic [mem_stage_pkg::LINE_W-1:0]     wdata_i,
	input  logic [mem_stage_pkg::LINE_BYTES-1:0] byte_en_i,
	output logic [mem_stage_pkg::LINE_W-1:0]     rdata_o
);
	import mem_stage_pkg::*;

	logic [LINE_W-1:0]             lines [LINE_COUNT];
	logic [$clog2(LINE_COUNT)-1:0] line_idx;

	assign line_idx = addr_i[$clog2(LINE_BYTES) +: $clog2(LINE_COUNT)];

	// Enable bit 63 is byte 0, the top byte of the line
	always_ff @(posedge clk)
	begin
		if (access_i && write_i)
		begin
			for (int b = 0; b < LINE_BYTES; b++)
			begin
				if (byte_en_i[b])
					lines[line_idx][8*b +: 8] <= wdata_i[8*b +: 8];
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			rdata_o <= '0;
		else if (access_i && !write_i)
			rdata_o <= lines[line_idx];
	end

endmodule

// File: verilog/mem_stage_pkg.sv
// ----------------------------------------
// Memory stage package
// Line geometry, memory op encodings, control register
// indices and the two views of an instruction word
// ----------------------------------------
package mem_stage_pkg;

	localparam int LINE_BYTES = 64;
	localparam int LANES      = 16;
	localparam int LINE_W     = 512;
	localparam int LINE_COUNT = 16; // Index from address bits 9:6

	localparam logic [29:0] CORE_ID = 30'h0000_01a5;

	// Memory op types
	localparam logic [3:0] MEM_B           = 4'd0;
	localparam logic [3:0] MEM_BX          = 4'd1;
	localparam logic [3:0] MEM_S           = 4'd2;
	localparam logic [3:0] MEM_SX          = 4'd3;
	localparam logic [3:0] MEM_L           = 4'd4;
	localparam logic [3:0] MEM_SYNC        = 4'd5;
	localparam logic [3:0] MEM_CONTROL_REG = 4'd6;
	localparam logic [3:0] MEM_BLOCK       = 4'd7;
	localparam logic [3:0] MEM_BLOCK_M     = 4'd8;
	localparam logic [3:0] MEM_BLOCK_IM    = 4'd9;
	localparam logic [3:0] MEM_STRIDED     = 4'd10;
	localparam logic [3:0] MEM_STRIDED_M   = 4'd11;
	localparam logic [3:0] MEM_STRIDED_IM  = 4'd12;
	localparam logic [3:0] MEM_SCGATH      = 4'd13;
	localparam logic [3:0] MEM_SCGATH_M    = 4'd14;
	localparam logic [3:0] MEM_SCGATH_IM   = 4'd15;

	localparam logic [1:0]  FMT_MEM = 2'b10;
	localparam logic [31:0] OP_NOP  = 32'h0000_0000;

	// Control register indices
	localparam logic [4:0] CR_STRAND_ID = 5'd0;
	localparam logic [4:0] CR_SCRATCH   = 5'd7;
	localparam logic [4:0] CR_STRAND_EN = 5'd30;
	localparam logic [4:0] CR_HALT      = 5'd31;

	// Same upper fields, low bits differ by op class
	typedef union packed {
		struct packed {
			logic [1:0] fmt;
			logic       is_load;
			logic [3:0] op_type;
			logic [9:0] offset;
			logic [4:0] mask_reg;
			logic [4:0] src_dst_reg;
			logic [4:0] ptr_reg;
		} mem;
		struct packed {
			logic [1:0]  fmt;
			logic        is_load;
			logic [3:0]  op_type;
			logic [19:0] unused;
			logic [4:0]  index; // Control register number
		} cr;
	} instr_word_u;

endpackage

// File: verilog/mem_subsystem_top.sv
// ----------------------------------------
// Memory subsystem top
// Memory access stage feeding the line store
// ----------------------------------------
`timescale 1ns/1ps

module mem_subsystem_top (
	input  logic                             clk,
	input  logic                             arst_n_i,
	input  logic                             flush_i,
	input  logic [31:0]                      instruction_i,
	input  logic [1:0]                       strand_i,
	input  logic [31:0]                      pc_i,
	input  logic [mem_stage_pkg::LINE_W-1:0] store_value_i,
	input  logic [mem_stage_pkg::LINE_W-1:0] result_i,
	input  logic [15:0]                      mask_i,
	input  logic [3:0]                       reg_lane_select_i,
	input  logic [31:0]                      base_addr_i,
	input  logic [31:0]                      strided_offset_i,
	input  logic                             has_writeback_i,
	input  logic [6:0]                       writeback_reg_i,
	input  logic                             writeback_is_vector_i,
	output logic [31:0]                      instruction_o,
	output logic                             has_writeback_o,
	output logic [6:0]                       writeback_reg_o,
	output logic                             writeback_is_vector_o,
	output logic [15:0]                      mask_o,
	output logic [mem_stage_pkg::LINE_W-1:0] result_o,
	output logic [3:0]                       cache_lane_select_o,
	output logic                             was_access_o,
	output logic [1:0]                       strand_o,
	output logic [31:0]                      pc_o,
	output logic [3:0]                       strand_enable_o,
	output logic                             daccess_o,
	output logic                             dwrite_o,
	output logic [mem_stage_pkg::LINE_W-1:0] load_line_o
);
	import mem_stage_pkg::*;

	logic [31:0]           daddress;
	logic [LINE_W-1:0]     ddata;
	logic [LINE_BYTES-1:0] write_mask;

	memory_access_stage u_stage (
		.clk                   (clk),
		.arst_n_i              (arst_n_i),
		.flush_i               (flush_i),
		.instruction_i         (instruction_i),
		.strand_i              (strand_i),
		.pc_i                  (pc_i),
		.store_value_i         (store_value_i),
		.result_i              (result_i),
		.mask_i                (mask_i),
		.reg_lane_select_i     (reg_lane_select_i),
		.base_addr_i           (base_addr_i),
		.strided_offset_i      (strided_offset_i),
		.has_writeback_i       (has_writeback_i),
		.writeback_reg_i       (writeback_reg_i),
		.writeback_is_vector_i (writeback_is_vector_i),
		.daccess_o             (daccess_o),
		.dwrite_o              (dwrite_o),
		.dsynchronized_o       (),
		.daddress_o            (daddress),
		.ddata_o               (ddata),
		.write_mask_o          (write_mask),
		.dstrand_o             (), // No per-strand state in the line store
		.instruction_o         (instruction_o),
		.has_writeback_o       (has_writeback_o),
		.writeback_reg_o       (writeback_reg_o),
		.writeback_is_vector_o (writeback_is_vector_o),
		.mask_o                (mask_o),
		.result_o              (result_o),
		.cache_lane_select_o   (cache_lane_select_o),
		.was_access_o          (was_access_o),
		.strand_o              (strand_o),
		.pc_o                  (pc_o),
		.strand_enable_o       (strand_enable_o)
	);

	line_store u_lines (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.access_i  (daccess_o),
		.write_i   (dwrite_o),
		.addr_i    (daddress),
		.wdata_i   (ddata),
		.byte_en_i (write_mask),
		.rdata_o   (load_line_o)
	);

endmodule

// File: verilog/memory_access_stage.sv
// ----------------------------------------
// Memory access stage
// Decodes memory ops, drives the data cache strobes,
// serves control registers, registers writeback fields
// ----------------------------------------
`timescale 1ns/1ps

module memory_access_stage (
	input  logic                                 clk,
	input  logic                                 arst_n_i,
	input  logic                                 flush_i,
	input  logic [31:0]                          instruction_i,
	input  logic [1:0]                           strand_i,
	input  logic [31:0]                          pc_i,
	input  logic [mem_stage_pkg::LINE_W-1:0]     store_value_i,
	input  logic [mem_stage_pkg::LINE_W-1:0]     result_i,
	input  logic [15:0]                          mask_i,
	input  logic [3:0]                           reg_lane_select_i,
	input  logic [31:0]                          base_addr_i,
	input  logic [31:0]                          strided_offset_i,
	input  logic                                 has_writeback_i,
	input  logic [6:0]                           writeback_reg_i,
	input  logic                                 writeback_is_vector_i,
	output logic                                 daccess_o,
	output logic                                 dwrite_o,
	output logic                                 dsynchronized_o,
	output logic [31:0]                          daddress_o,
	output logic [mem_stage_pkg::LINE_W-1:0]     ddata_o,
	output logic [mem_stage_pkg::LINE_BYTES-1:0] write_mask_o,
	output logic [1:0]                           dstrand_o,
	output logic [31:0]                          instruction_o,
	output logic                                 has_writeback_o,
	output logic [6:0]                           writeback_reg_o,
	output logic                                 writeback_is_vector_o,
	output logic [15:0]                          mask_o,
	output logic [mem_stage_pkg::LINE_W-1:0]     result_o,
	output logic [3:0]                           cache_lane_select_o,
	output logic                                 was_access_o,
	output logic [1:0]                           strand_o,
	output logic [31:0]                          pc_o,
	output logic [3:0]                           strand_enable_o
);
	import mem_stage_pkg::*;

	instr_word_u       instr;
	logic              is_mem;
	logic              is_cr;
	logic              is_block;
	logic              is_lane_op;
	logic              lane_active;
	logic              unaligned_addr;
	logic              cr_wr_en;
	logic [3:0]        cache_lane;
	logic [15:0]       word_mask;
	logic [31:0]       cr_rd_value;
	logic [LINE_W-1:0] result_nxt;

	assign instr       = instruction_i;
	assign is_mem      = instr.mem.fmt == FMT_MEM;
	assign is_cr       = is_mem && instr.mem.op_type == MEM_CONTROL_REG;
	assign lane_active = mask_i[~reg_lane_select_i]; // Mask bit 15 is lane 0
	assign cr_wr_en    = is_cr && !instr.cr.is_load && !flush_i;

	// Op class and alignment of the address in result_i
	always_comb
	begin
		is_block   = 1'b0;
		is_lane_op = 1'b0;
		case (instr.mem.op_type)
			MEM_B, MEM_BX, MEM_CONTROL_REG:
				unaligned_addr = 1'b0;
			MEM_S, MEM_SX:
				unaligned_addr = result_i[0];
			MEM_L, MEM_SYNC:
				unaligned_addr = result_i[1:0] != 2'b00;
			MEM_BLOCK, MEM_BLOCK_M, MEM_BLOCK_IM:
			begin
				is_block       = 1'b1;
				unaligned_addr = result_i[5:0] != 6'd0;
			end
			default:
			begin
				// Strided and gather pointers are truncated to a word lane
				is_lane_op     = 1'b1;
				unaligned_addr = 1'b0;
			end
		endcase
	end

	always_comb
	begin
		if (is_block)
			word_mask = mask_i;
		else if (is_lane_op && !lane_active)
			word_mask = 16'h0000;
		else
			word_mask = 16'h8000 >> cache_lane;
	end

	assign daccess_o       = is_mem && !is_cr && !flush_i && (!is_lane_op || lane_active);
	assign dwrite_o        = daccess_o && !instr.mem.is_load;
	assign dsynchronized_o = is_mem && instr.mem.op_type == MEM_SYNC;
	assign dstrand_o       = strand_i;

	address_generator u_addr (
		.op_type_i         (instr.mem.op_type),
		.result_i          (result_i),
		.base_addr_i       (base_addr_i),
		.strided_offset_i  (strided_offset_i),
		.reg_lane_select_i (reg_lane_select_i),
		.daddress_o        (daddress_o),
		.cache_lane_o      (cache_lane)
	);

	store_formatter u_fmt (
		.op_type_i         (instr.mem.op_type),
		.addr_low_i        (result_i[1:0]),
		.store_value_i     (store_value_i),
		.reg_lane_select_i (reg_lane_select_i),
		.word_mask_i       (word_mask),
		.store_data_o      (ddata_o),
		.write_mask_o      (write_mask_o)
	);

	control_registers u_cregs (
		.clk             (clk),
		.arst_n_i        (arst_n_i),
		.wr_en_i         (cr_wr_en),
		.cr_index_i      (instr.cr.index),
		.wr_value_i      (store_value_i[31:0]),
		.strand_i        (strand_i),
		.rd_value_o      (cr_rd_value),
		.strand_enable_o (strand_enable_o)
	);

	assign result_nxt = is_cr ? {{(LINE_W-32){1'b0}}, cr_rd_value} : result_i;

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			instruction_o   <= OP_NOP;
			has_writeback_o <= 1'b0;
			was_access_o    <= 1'b0;
		end
		else
		begin
			instruction_o   <= flush_i ? OP_NOP : instruction_i;
			has_writeback_o <= has_writeback_i && !flush_i;
			was_access_o    <= daccess_o;
		end
	end

	always_ff @(posedge clk)
	begin
		result_o              <= result_nxt;
		mask_o                <= mask_i;
		writeback_reg_o       <= writeback_reg_i;
		writeback_is_vector_o <= writeback_is_vector_i;
		cache_lane_select_o   <= cache_lane;
		strand_o              <= strand_i;
		pc_o                  <= pc_i;
	end

endmodule

// File: verilog/store_formatter.sv
// ----------------------------------------
// Store formatter
// Places and byte-swaps store data into big-endian
// line order and builds the 64-bit byte write mask
// ----------------------------------------
`timescale 1ns/1ps

module store_formatter (
	input  logic [3:0]                           op_type_i,
	input  logic [1:0]                           addr_low_i,
	input  logic [mem_stage_pkg::LINE_W-1:0]     store_value_i,
	input  logic [3:0]                           reg_lane_select_i,
	input  logic [15:0]                          word_mask_i,
	output logic [mem_stage_pkg::LINE_W-1:0]     store_data_o,
	output logic [mem_stage_pkg::LINE_BYTES-1:0] write_mask_o
);
	import mem_stage_pkg::*;

	logic [31:0] lane_value;
	logic [31:0] word_data;
	logic [3:0]  byte_mask;
	logic        is_block;

	function automatic logic [31:0] swap32(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	assign lane_value = store_value_i[{~reg_lane_select_i, 5'd0} +: 32];

	always_comb
	begin
		byte_mask = 4'b1111;
		word_data = swap32(store_value_i[31:0]); // Word, sync, control reg
		is_block  = 1'b0;
		case (op_type_i)
			MEM_B, MEM_BX:
			begin
				byte_mask = 4'b1000 >> addr_low_i;
				word_data = {24'd0, store_value_i[7:0]} << {~addr_low_i, 3'd0};
			end
			MEM_S, MEM_SX:
			begin
				byte_mask = addr_low_i[1] ? 4'b0011 : 4'b1100;
				word_data = addr_low_i[1] ?
					{16'd0, store_value_i[7:0], store_value_i[15:8]} :
					{store_value_i[7:0], store_value_i[15:8], 16'd0};
			end
			MEM_STRIDED, MEM_STRIDED_M, MEM_STRIDED_IM,
			MEM_SCGATH, MEM_SCGATH_M, MEM_SCGATH_IM:
				word_data = swap32(lane_value);
			MEM_BLOCK, MEM_BLOCK_M, MEM_BLOCK_IM:
				is_block = 1'b1;
			default: ;
		endcase
	end

	// Block ops swap every lane, the rest replicate one word
	always_comb
	begin
		for (int i = 0; i < LANES; i++)
		begin
			if (is_block)
				store_data_o[32*i +: 32] = swap32(store_value_i[32*i +: 32]);
			else
				store_data_o[32*i +: 32] = word_data;
		end
	end

	always_comb
	begin
		for (int w = 0; w < LANES; w++)
			write_mask_o[4*w +: 4] = word_mask_i[w] ? byte_mask : 4'b0000;
	end

endmodule
